//--- logic/lane_pkg.sv
// ##########################################################
// Lane bank shared sizes
// Word width, lane count and per-lane buffer geometry
// ##########################################################

package lane_pkg;

  // ##########################################################
  // Stream word
  // ##########################################################

  localparam int DATA_WIDTH = 32;

  // ##########################################################
  // Lane bank geometry
  // ##########################################################

  // Lanes are served round-robin on both sides
  localparam int NUM_LANES = 4;

  // Lane index width, log2 of NUM_LANES
  localparam int LANE_SEL_WIDTH = 2;

  // ##########################################################
  // Per-lane buffering
  // ##########################################################

  localparam int CORE_DEPTH = 16;      // Words in one FIFO core
  localparam int CORE_ADDR_WIDTH = 4;  // Pointer width for CORE_DEPTH

  // Core output, middle and output registers of the prefetch stage
  localparam int PREFETCH_WORDS = 3;

  // A lane can hold CORE_DEPTH + PREFETCH_WORDS words with no reads

endpackage

//--- logic/bram_fifo_core.sv
// ##########################################################
// Block RAM style FIFO core
// Registered read data, one cycle of read latency
// ##########################################################

`timescale 1ns/10ps

module bram_fifo_core (
  input  logic                            RD_CLK,
  input  logic                            RESET,
  input  logic                            wr_en,
  input  logic                            rd_en,
  input  logic [lane_pkg::DATA_WIDTH-1:0] din,
  output logic [lane_pkg::DATA_WIDTH-1:0] dout,
  output logic                            full,
  output logic                            empty
);

  logic [lane_pkg::DATA_WIDTH-1:0]    mem [lane_pkg::CORE_DEPTH];
  logic [lane_pkg::CORE_ADDR_WIDTH-1:0] wr_ptr;
  logic [lane_pkg::CORE_ADDR_WIDTH-1:0] rd_ptr;
  logic [lane_pkg::CORE_ADDR_WIDTH:0]   count;        // Words stored
  logic [lane_pkg::CORE_ADDR_WIDTH:0]   ready_count;  // Words readable
  logic                                 wr_commit;

  // ##########################################################
  // Memory array
  // ##########################################################

  always_ff @(posedge RD_CLK) begin
    if (wr_en)
      mem[wr_ptr] <= din;
  end

  // Output register of the RAM, no reset on data
  always_ff @(posedge RD_CLK) begin
    if (rd_en)
      dout <= mem[rd_ptr];
  end

  // ##########################################################
  // Pointers and occupancy
  // ##########################################################

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      wr_commit <= 1'b0;
    end else begin
      wr_commit <= wr_en;  // A written word becomes readable a cycle later
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Write side count, drives full
  always_ff @(posedge RD_CLK) begin
    if (RESET)
      count <= '0;
    else if (wr_en && !rd_en)
      count <= count + 1'b1;
    else if (!wr_en && rd_en)
      count <= count - 1'b1;
  end

  // Read side count, lags writes by the commit cycle
  always_ff @(posedge RD_CLK) begin
    if (RESET)
      ready_count <= '0;
    else if (wr_commit && !rd_en)
      ready_count <= ready_count + 1'b1;
    else if (!wr_commit && rd_en)
      ready_count <= ready_count - 1'b1;
  end

  assign full  = (count == (lane_pkg::CORE_ADDR_WIDTH + 1)'(lane_pkg::CORE_DEPTH));
  assign empty = (ready_count == '0);

endmodule

//--- logic/fwft_lane.sv
// ##########################################################
// First-word-fall-through lane
// FIFO core followed by a three register prefetch stage
// ##########################################################

`timescale 1ns/10ps

module fwft_lane (
  input  logic                            RD_CLK,
  input  logic                            RESET,
  input  logic                            wren,
  input  logic                            rden,
  input  logic [lane_pkg::DATA_WIDTH-1:0] din,
  output logic [lane_pkg::DATA_WIDTH-1:0] dout,
  output logic                            empty,
  output logic                            full
);

  logic [lane_pkg::DATA_WIDTH-1:0] fifo_dout;
  logic [lane_pkg::DATA_WIDTH-1:0] middle_dout;
  logic                            fifo_empty;
  logic                            fifo_rden;
  logic                            fifo_valid;    // Core output register holds a word
  logic                            middle_valid;
  logic                            dout_valid;
  logic                            will_update_middle;
  logic                            will_update_dout;

  // ##########################################################
  // FIFO core
  // ##########################################################

  bram_fifo_core u_core (
    .RD_CLK (RD_CLK),
    .RESET  (RESET),
    .wr_en  (wren),
    .rd_en  (fifo_rden),
    .din    (din),
    .dout   (fifo_dout),
    .full   (full),
    .empty  (fifo_empty)
  );

  // ##########################################################
  // Prefetch control
  // ##########################################################

  // Output register takes a word when it is free or being consumed
  assign will_update_dout = (middle_valid || fifo_valid) && (rden || !dout_valid);

  // Park the core word in the middle unless it goes straight to the output
  assign will_update_middle = fifo_valid && (middle_valid == will_update_dout);

  // Keep reading while any of the three stages can take a word
  assign fifo_rden = !fifo_empty && !(middle_valid && dout_valid && fifo_valid);

  assign empty = !dout_valid;

  // ##########################################################
  // Stage data
  // ##########################################################

  always_ff @(posedge RD_CLK) begin
    if (will_update_middle)
      middle_dout <= fifo_dout;
  end

  always_ff @(posedge RD_CLK) begin
    if (will_update_dout)
      dout <= middle_valid ? middle_dout : fifo_dout;  // Oldest word first
  end

  // ##########################################################
  // Stage valid flags
  // ##########################################################

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      fifo_valid <= 1'b0;
    end else begin
      if (fifo_rden)
        fifo_valid <= 1'b1;
      else if (will_update_middle || will_update_dout)
        fifo_valid <= 1'b0;
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      middle_valid <= 1'b0;
    end else begin
      if (will_update_middle)
        middle_valid <= 1'b1;
      else if (will_update_dout)
        middle_valid <= 1'b0;  // Middle word moved to output
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      dout_valid <= 1'b0;
    end else begin
      if (will_update_dout)
        dout_valid <= 1'b1;
      else if (rden)
        dout_valid <= 1'b0;
    end
  end

endmodule

//--- logic/lane_dispatcher.sv
// ##########################################################
// Lane dispatcher
// Steers accepted writes round-robin across the lanes
// ##########################################################

`timescale 1ns/10ps

module lane_dispatcher (
  input  logic                           RD_CLK,
  input  logic                           RESET,
  input  logic                           wren,
  input  logic [lane_pkg::NUM_LANES-1:0] lane_full,
  output logic                           full,
  output logic [lane_pkg::NUM_LANES-1:0] lane_wren
);

  logic [lane_pkg::LANE_SEL_WIDTH-1:0] wr_sel;  // Lane taking the next word
  logic                                accept;

  // ##########################################################
  // Write steering
  // ##########################################################

  // Bank is full when the lane in line is full
  assign full   = lane_full[wr_sel];
  assign accept = wren && !full;

  always_comb begin
    lane_wren = '0;
    if (accept)
      lane_wren[wr_sel] = 1'b1;
  end

  // ##########################################################
  // Round-robin pointer
  // ##########################################################

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      wr_sel <= '0;
    end else if (accept) begin
      if (wr_sel == lane_pkg::LANE_SEL_WIDTH'(lane_pkg::NUM_LANES - 1))
        wr_sel <= '0;
      else
        wr_sel <= wr_sel + 1'b1;
    end
  end

endmodule

//--- logic/lane_collector.sv
// ##########################################################
// Lane collector
// Presents the head word of the lane in turn, round-robin
// ##########################################################

`timescale 1ns/10ps

module lane_collector (
  input  logic                                                   RD_CLK,
  input  logic                                                   RESET,
  input  logic                                                   rden,
  input  logic [lane_pkg::NUM_LANES-1:0][lane_pkg::DATA_WIDTH-1:0] lane_dout,
  input  logic [lane_pkg::NUM_LANES-1:0]                         lane_empty,
  output logic [lane_pkg::DATA_WIDTH-1:0]                        dout,
  output logic                                                   empty,
  output logic [lane_pkg::NUM_LANES-1:0]                         lane_rden
);

  logic [lane_pkg::LANE_SEL_WIDTH-1:0] rd_sel;  // Lane holding the oldest word
  logic                                consume;

  // ##########################################################
  // Output selection
  // ##########################################################

  // Head of the current lane falls through to the bank output
  assign dout  = lane_dout[rd_sel];
  assign empty = lane_empty[rd_sel];

  assign consume = rden && !empty;

  // Only the current lane sees the read strobe
  always_comb begin
    lane_rden = '0;
    if (consume)
      lane_rden[rd_sel] = 1'b1;
  end

  // ##########################################################
  // Round-robin pointer
  // ##########################################################

  // Same order as the dispatcher, so words leave in arrival order
  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      rd_sel <= '0;
    end else if (consume) begin
      if (rd_sel == lane_pkg::LANE_SEL_WIDTH'(lane_pkg::NUM_LANES - 1))
        rd_sel <= '0;
      else
        rd_sel <= rd_sel + 1'b1;
    end
  end

  // A lane that is empty here stalls the whole output,
  // later lanes may already hold words but must wait their turn

endmodule

//--- logic/lane_bank_top.sv
// ##########################################################
// Multi-lane FWFT stream buffer
// Dispatcher, four prefetching lanes and an in-order collector
// ##########################################################

`timescale 1ns/10ps

module lane_bank_top (
  input  logic                            RD_CLK,
  input  logic                            RESET,
  input  logic                            wren,
  input  logic [lane_pkg::DATA_WIDTH-1:0] din,
  input  logic                            rden,
  output logic                            full,
  output logic [lane_pkg::DATA_WIDTH-1:0] dout,
  output logic                            empty
);

  logic [lane_pkg::NUM_LANES-1:0]                          lane_wren;
  logic [lane_pkg::NUM_LANES-1:0]                          lane_full;
  logic [lane_pkg::NUM_LANES-1:0]                          lane_rden;
  logic [lane_pkg::NUM_LANES-1:0]                          lane_empty;
  logic [lane_pkg::NUM_LANES-1:0][lane_pkg::DATA_WIDTH-1:0] lane_dout;

  // ##########################################################
  // Write side
  // ##########################################################

  lane_dispatcher u_dispatcher (
    .RD_CLK    (RD_CLK),
    .RESET     (RESET),
    .wren      (wren),
    .lane_full (lane_full),
    .full      (full),
    .lane_wren (lane_wren)
  );

  // ##########################################################
  // Lanes
  // ##########################################################

  for (genvar i = 0; i < lane_pkg::NUM_LANES; i++) begin : gen_lane
    fwft_lane u_lane (
      .RD_CLK (RD_CLK),
      .RESET  (RESET),
      .wren   (lane_wren[i]),
      .rden   (lane_rden[i]),
      .din    (din),            // Shared, only the strobed lane takes it
      .dout   (lane_dout[i]),
      .empty  (lane_empty[i]),
      .full   (lane_full[i])
    );
  end

  // Read side
  lane_collector u_collector (
    .RD_CLK     (RD_CLK),
    .RESET      (RESET),
    .rden       (rden),
    .lane_dout  (lane_dout),
    .lane_empty (lane_empty),
    .dout       (dout),
    .empty      (empty),
    .lane_rden  (lane_rden)
  );

endmodule

//--- tests/lane_bank_tb.sv
// ##########################################################
// Lane bank testbench
// Random streams against a queue model, capacity and latency
// ##########################################################

`timescale 1ns/10ps

module lane_bank_tb;

  localparam int LANE_WORDS = lane_pkg::CORE_DEPTH + lane_pkg::PREFETCH_WORDS;
  localparam int BANK_WORDS = lane_pkg::NUM_LANES * LANE_WORDS;

  logic                            RD_CLK;
  logic                            RESET;
  logic                            wren;
  logic                            rden;
  logic [lane_pkg::DATA_WIDTH-1:0] din;
  logic                            full;
  logic [lane_pkg::DATA_WIDTH-1:0] dout;
  logic                            empty;

  logic [lane_pkg::DATA_WIDTH-1:0] model_q [$];  // Accepted, not yet consumed
  string                           test_name = "reset";
  int                              n_wr = 0;
  int                              n_rd = 0;

  lane_bank_top DUT (
    .RD_CLK (RD_CLK),
    .RESET  (RESET),
    .wren   (wren),
    .din    (din),
    .rden   (rden),
    .full   (full),
    .dout   (dout),
    .empty  (empty)
  );

  initial begin
    RD_CLK = 1'b0;
    forever #50 RD_CLK = ~RD_CLK;
  end

  // ##########################################################
  // Error reporting and helpers
  // ##########################################################

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    stop_on_error($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  function automatic logic random_bit();
    return ($urandom() & 32'd1) != 32'd0;
  endfunction

  // One edge, counting what the bank took and gave on it
  task automatic advance();
    @(posedge RD_CLK);
    if (wren && !full)
      n_wr++;
    if (rden && !empty)
      n_rd++;
  endtask

  task automatic drain_bank(input string why);
    int cycles;
    cycles = 0;
    wren <= 1'b0;
    rden <= 1'b1;
    while (n_rd != n_wr) begin
      advance();
      cycles++;
      if (cycles > 1000)
        stop_on_error($sformatf("timeout while draining the bank after %s", why));
    end
    rden <= 1'b0;
  endtask

  // ##########################################################
  // Scoreboard
  // ##########################################################

  always @(posedge RD_CLK) begin
    if (!RESET) begin
      assert (empty || model_q.size() != 0)
        else stop_on_error({test_name, ": empty is low but no word is expected"});
      if (rden && !empty) begin
        assert (model_q.size() != 0)
          else stop_on_error({test_name, ": word read with none expected"});
        assert (dout == model_q[0]) else report_mismatch(test_name, model_q[0], dout);
        void'(model_q.pop_front());
      end
      if (wren && !full)
        model_q.push_back(din);
    end
  end

  // ##########################################################
  // Stimulus
  // ##########################################################

  initial begin
    int cycles;
    int start_wr;
    int start_rd;
    int high_run;
    int edges;
    logic [lane_pkg::DATA_WIDTH-1:0] word;

    void'($urandom(32'h5edf582e));
    RESET = 1'b1;
    wren  = 1'b0;
    rden  = 1'b0;
    din   = '0;
    repeat (3) @(posedge RD_CLK);
    RESET <= 1'b0;

    @(posedge RD_CLK);
    assert (empty == 1'b1) else report_mismatch("reset empty", 32'd1, 32'(empty));
    assert (full == 1'b0) else report_mismatch("reset full", 32'd0, 32'(full));

    // Stream with reads always on
    test_name = "order";
    cycles = 0;
    start_wr = n_wr;
    while (n_wr - start_wr < 200) begin
      advance();
      cycles++;
      if (cycles > 4000)
        stop_on_error("timeout while writing the ordered stream");
      wren <= (n_wr - start_wr < 200) ? random_bit() : 1'b0;
      din  <= $urandom();
      rden <= 1'b1;
    end
    drain_bank("the ordered stream");

    // Fill with reads held off
    test_name = "capacity";
    start_wr = n_wr;
    high_run = 0;
    cycles = 0;
    wren <= 1'b1;
    din  <= $urandom();
    while (high_run < 10) begin
      advance();
      high_run = full ? high_run + 1 : 0;
      din <= $urandom();
      cycles++;
      if (cycles > 500)
        stop_on_error("timeout waiting for full to stay high");
    end
    wren <= 1'b0;
    assert (n_wr - start_wr == BANK_WORDS)
      else report_mismatch(test_name, BANK_WORDS, n_wr - start_wr);

    // Read until the bank runs dry
    test_name = "drain";
    start_rd = n_rd;
    cycles = 0;
    rden <= 1'b1;
    do begin
      advance();
      cycles++;
      if (cycles > 1000)
        stop_on_error("timeout waiting for empty after the capacity fill");
    end while (!empty);
    rden <= 1'b0;
    assert (n_rd - start_rd == BANK_WORDS)
      else report_mismatch(test_name, BANK_WORDS, n_rd - start_rd);
    repeat (5) begin
      @(negedge RD_CLK);
      assert (empty == 1'b1) else report_mismatch(test_name, 32'd1, 32'(empty));
      assert (model_q.size() == 0) else report_mismatch(test_name, 32'd0, model_q.size());
    end

    // Both sides random
    test_name = "backpressure";
    repeat (300) begin
      advance();
      wren <= random_bit();
      rden <= random_bit();
      din  <= $urandom();
    end
    drain_bank("random back-pressure");

    // Single word into an idle bank
    test_name = "latency";
    repeat (4) advance();
    word = $urandom();
    wren <= 1'b1;
    din  <= word;
    advance();                 // Edge that samples wren
    wren <= 1'b0;
    edges = 0;
    cycles = 0;
    do begin
      @(posedge RD_CLK);
      edges++;
      @(negedge RD_CLK);
      cycles++;
      if (cycles > 20)
        stop_on_error("timeout waiting for empty to fall after a single write");
    end while (empty);
    assert (edges == 3) else report_mismatch(test_name, 32'd3, edges);
    assert (dout == word) else report_mismatch(test_name, word, dout);
    drain_bank("the latency write");
    repeat (2) advance();

    $display("All checks passed");
    $finish;
  end

endmodule

//--- tb.f
logic/lane_pkg.sv
logic/bram_fifo_core.sv
logic/fwft_lane.sv
logic/lane_dispatcher.sv
logic/lane_collector.sv
logic/lane_bank_top.sv
tests/lane_bank_tb.sv

//--- Makefile
# Verilator build and run of the lane bank testbench

TOP = lane_bank_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir -o sim

# Pass only when the simulation prints the pass message
run: compile
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
